// File: verilog.f
src/div_pkg.sv
src/div_operand_prep.sv
src/div_subshift.sv
src/div_result_fix.sv
src/div_unit_top.sv
tb/div_unit_asserts.sv
tb/tb_div_unit.sv

// File: Bender.yml
package:
  name: div_unit

sources:
  - src/div_pkg.sv
  - src/div_operand_prep.sv
  - src/div_subshift.sv
  - src/div_result_fix.sv
  - src/div_unit_top.sv
  - target: test
    files:
      - tb/div_unit_asserts.sv
      - tb/tb_div_unit.sv

// File: tb/tb_div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_div_unit
   import div_pkg::*;
();

   logic     clk;
   logic     rst_n;
   logic     req_valid;
   div_req_t req;
   logic     rsp_valid;
   div_rsp_t rsp;
   logic     busy;

   int       value_errors;
   int       timeouts;

   div_unit_top u_dut (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .req_valid_i(req_valid),
      .req_i      (req),
      .rsp_valid_o(rsp_valid),
      .rsp_o      (rsp),
      .busy_o     (busy)
   );

   bind div_unit_top div_unit_asserts u_asserts (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_valid_i(req_valid_i),
      .busy_i     (busy_o),
      .rsp_valid_i(rsp_valid_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // RISC-V divide rules, including divide by zero and signed overflow.
   function automatic div_rsp_t model_divide(div_req_t r);
      div_rsp_t exp;
      exp.div_zero = (r.divisor == '0);
      if (r.divisor == '0) begin
         exp.quotient  = '1;
         exp.remainder = r.dividend;
      end else if (r.is_signed && r.dividend == {1'b1, {(DATA_W-1){1'b0}}} &&
                   r.divisor == '1) begin
         exp.quotient  = r.dividend;
         exp.remainder = '0;
      end else if (r.is_signed) begin
         exp.quotient  = word_t'($signed(r.dividend) / $signed(r.divisor));
         exp.remainder = word_t'($signed(r.dividend) % $signed(r.divisor));
      end else begin
         exp.quotient  = r.dividend / r.divisor;
         exp.remainder = r.dividend % r.divisor;
      end
      return exp;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while (busy && cycles < 100) begin
         next_cycle();
         cycles++;
      end
      if (busy) begin
         $display("Timeout at %0t: unit still busy after 100 cycles", $time);
         timeouts++;
      end
   endtask

   task automatic wait_response(output logic seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < 100) begin
         next_cycle();
         cycles++;
         seen = rsp_valid;
      end
      if (!seen) begin
         $display("Timeout at %0t: no response within 100 cycles", $time);
         timeouts++;
      end
   endtask

   task automatic issue_request(input div_req_t r);
      wait_idle();
      req_valid = 1'b1;
      req       = r;
      next_cycle();
      req_valid = 1'b0;
   endtask

   task automatic check_response(input div_req_t r);
      div_rsp_t exp;
      exp = model_divide(r);
      assert (rsp == exp) else begin
         $display("FAIL %0t: a=%h b=%h signed=%0d got q=%h r=%h z=%0d exp q=%h r=%h z=%0d",
                  $time, r.dividend, r.divisor, r.is_signed, rsp.quotient, rsp.remainder,
                  rsp.div_zero, exp.quotient, exp.remainder, exp.div_zero);
         value_errors++;
      end
      if (!r.is_signed && r.divisor != '0) begin
         assert (rsp.quotient * r.divisor + rsp.remainder == r.dividend) else begin
            $display("FAIL %0t: q*b+r differs from a for a=%h b=%h",
                     $time, r.dividend, r.divisor);
            value_errors++;
         end
      end
      if (r.is_signed && r.divisor != '0 && rsp.remainder != '0) begin
         assert (rsp.remainder[DATA_W-1] == r.dividend[DATA_W-1]) else begin
            $display("FAIL %0t: remainder sign differs from dividend for a=%h b=%h",
                     $time, r.dividend, r.divisor);
            value_errors++;
         end
      end
   endtask

   task automatic run_division(input word_t a, input word_t b, input logic s);
      div_req_t r;
      logic     seen;
      r.dividend  = a;
      r.divisor   = b;
      r.is_signed = s;
      issue_request(r);
      wait_response(seen);
      if (seen) begin
         check_response(r);
      end
   endtask

   // Requests in the start cycle and mid-run must both be lost.
   task automatic drop_while_busy();
      div_req_t first;
      div_req_t second;
      logic     seen;
      int       cycles;
      first.dividend  = 32'd1000;
      first.divisor   = 32'd9;
      first.is_signed = 1'b0;
      second.dividend = 32'hffff_ff9c;
      second.divisor  = 32'd5;
      second.is_signed = 1'b1;
      issue_request(first);
      req_valid = 1'b1;
      req       = second;
      next_cycle();
      req_valid = 1'b0;
      repeat (10) next_cycle();
      req_valid = 1'b1;
      next_cycle();
      req_valid = 1'b0;
      wait_response(seen);
      if (seen) begin
         check_response(first);
      end
      cycles = 0;
      while (cycles < 40) begin
         next_cycle();
         cycles++;
         assert (!rsp_valid) else begin
            $display("FAIL %0t: extra response after a dropped request", $time);
            value_errors++;
         end
      end
   endtask

   initial begin
      int    asserts_failed;
      word_t a;
      word_t b;
      void'($urandom(91));
      value_errors = 0;
      timeouts     = 0;
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      next_cycle();

      run_division(32'd100, 32'd7, 1'b0);
      run_division(32'd100, 32'd7, 1'b1);
      run_division(-32'sd100, 32'd7, 1'b1);
      run_division(32'd100, -32'sd7, 1'b1);
      run_division(-32'sd100, -32'sd7, 1'b1);
      run_division(32'd5, 32'd9, 1'b0);
      run_division(32'hdead_beef, 32'd1, 1'b0);
      // Divide by zero, both flavors.
      run_division(32'h1234_5678, 32'd0, 1'b0);
      run_division(32'h8765_4321, 32'd0, 1'b1);
      run_division(32'h0000_0000, 32'd0, 1'b1);
      // Signed overflow, and the same operands unsigned.
      run_division(32'h8000_0000, 32'hffff_ffff, 1'b1);
      run_division(32'h8000_0000, 32'hffff_ffff, 1'b0);

      repeat (40) begin
         a = $urandom();
         b = $urandom() >> ($urandom() % DATA_W);
         run_division(a, b, 1'b0);
      end
      repeat (40) begin
         a = $urandom();
         b = $urandom() >> ($urandom() % DATA_W);
         if ($urandom() % 2 == 1) begin
            b = -b;
         end
         run_division(a, b, 1'b1);
      end

      drop_while_busy();

      asserts_failed = u_dut.u_asserts.fail_count;
      $display("Errors: %0d value, %0d timeout, %0d assertion",
               value_errors, timeouts, asserts_failed);
      if (value_errors + timeouts + asserts_failed == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/div_unit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit_asserts
   import div_pkg::*;
(
   input logic clk_i,
   input logic rst_n_i,
   input logic req_valid_i,
   input logic busy_i,
   input logic rsp_valid_i
);

   int   fail_count = 0;
   logic accepted;

   assign accepted = req_valid_i && !busy_i;

   // Unit comes out of reset idle.
   a_reset_idle: assert property (@(posedge clk_i)
      !rst_n_i |=> !busy_i && !rsp_valid_i)
   else begin
      fail_count++;
      $error("unit not idle after reset");
   end

   // Busy from the next cycle on, one response exactly DATA_W+3 cycles later.
   a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      accepted |=> (busy_i && !rsp_valid_i)[*(DATA_W + 2)] ##1 (rsp_valid_i && !busy_i))
   else begin
      fail_count++;
      $error("busy or response timing wrong after an accepted request");
   end

   a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_valid_i |=> !rsp_valid_i)
   else begin
      fail_count++;
      $error("response strobe longer than one cycle");
   end

   a_rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_valid_i |-> $past(accepted, DATA_W + 3))
   else begin
      fail_count++;
      $error("response without a matching accepted request");
   end

   // Busy only rises in the cycle after an accepted request.
   a_busy_from_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(busy_i) |-> $past(accepted))
   else begin
      fail_count++;
      $error("busy rose without an accepted request");
   end

endmodule

`default_nettype wire

// File: src/div_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit_top
   import div_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,

   input  logic     req_valid_i,
   input  div_req_t req_i,

   output logic     rsp_valid_o,
   output div_rsp_t rsp_o,
   output logic     busy_o
);

   logic      start;
   word_t     dividend_abs;
   word_t     divisor_abs;
   div_meta_t meta;

   logic      done;
   logic      core_busy;
   word_t     quotient_raw;
   word_t     remainder_raw;
   logic      busy;

   // Pending start counts as busy so the start cycle refuses a new request.
   assign busy = core_busy | start;

   div_operand_prep u_operand_prep (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_valid_i(req_valid_i),
      .req_i      (req_i),
      .busy_i     (busy),
      .start_o    (start),
      .dividend_o (dividend_abs),
      .divisor_o  (divisor_abs),
      .meta_o     (meta)
   );

   div_subshift u_subshift (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (start),
      .dividend_i (dividend_abs),
      .divisor_i  (divisor_abs),
      .done_o     (done),
      .busy_o     (core_busy),
      .quotient_o (quotient_raw),
      .remainder_o(remainder_raw)
   );

   div_result_fix u_result_fix (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (start),
      .meta_i     (meta),
      .done_i     (done),
      .quotient_i (quotient_raw),
      .remainder_i(remainder_raw),
      .rsp_valid_o(rsp_valid_o),
      .rsp_o      (rsp_o)
   );

   assign busy_o = busy;

endmodule

`default_nettype wire

// File: src/div_result_fix.sv
`timescale 1ns/1ns
`default_nettype none

module div_result_fix
   import div_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,

   input  logic      start_i,
   input  div_meta_t meta_i,

   input  logic      done_i,
   input  word_t     quotient_i,
   input  word_t     remainder_i,

   output logic      rsp_valid_o,
   output div_rsp_t  rsp_o
);

   div_meta_t meta_q;
   div_rsp_t  rsp_d;
   div_rsp_t  rsp_q;
   logic      rsp_valid_q;

   // Flags of the division in flight.
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         meta_q <= meta_i;
      end
   end

   always_comb begin
      rsp_d.quotient  = meta_q.neg_q ? -quotient_i  : quotient_i;
      rsp_d.remainder = meta_q.neg_r ? -remainder_i : remainder_i;
      rsp_d.div_zero  = meta_q.div_zero;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rsp_valid_q <= 1'b0;
         rsp_q       <= '0;
      end else begin
         rsp_valid_q <= done_i;
         // Response holds until the next division completes.
         if (done_i) begin
            rsp_q <= rsp_d;
         end
      end
   end

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: src/div_subshift.sv
`timescale 1ns/1ns
`default_nettype none

module div_subshift
   import div_pkg::*;
(
   input  logic  clk_i,
   input  logic  rst_n_i,

   input  logic  start_i,
   input  word_t dividend_i,
   input  word_t divisor_i,

   output logic  done_o,
   output logic  busy_o,
   output word_t quotient_o,
   output word_t remainder_o
);

   core_state_t state_q;
   core_state_t state_d;
   cnt_t        cnt_q;
   cnt_t        cnt_d;

   // Upper part holds the partial remainder, lower part the dividend.
   // Quotient bits shift in from the right as dividend bits leave.
   logic [DQR_W-1:0]   dqr_q;
   logic [DQR_W-1:0]   dqr_d;
   word_t              divisor_q;
   word_t              divisor_d;

   // Trial difference for the step after the one being computed.
   logic [TRIAL_W-1:0] trial_q;
   logic [TRIAL_W-1:0] trial_d;
   logic               borrow;

   assign borrow = trial_q[TRIAL_W-1];

   always_comb begin
      state_d   = state_q;
      cnt_d     = cnt_q;
      dqr_d     = dqr_q;
      divisor_d = divisor_q;

      case (state_q)
         IDLE: begin
            if (start_i) begin
               dqr_d     = {{(DATA_W + 1){1'b0}}, dividend_i};
               divisor_d = divisor_i;
               cnt_d     = '0;
               state_d   = RUN;
            end
         end

         RUN: begin
            if (!borrow) begin
               // Subtraction fits, keep the difference and set the quotient bit.
               dqr_d = {trial_q[DATA_W:0], dqr_q[DATA_W-2:0], 1'b1};
            end else begin
               // Restore by shifting the old remainder.
               dqr_d = {dqr_q[DQR_W-2:0], 1'b0};
            end
            cnt_d = cnt_q + 1'b1;
            if (cnt_q == cnt_t'(DATA_W - 1)) begin
               state_d = DONE;
            end
         end

         DONE: begin
            state_d = IDLE;
         end

         default: begin
            state_d = IDLE;
         end
      endcase

      // Shifted remainder with the next dividend bit, minus the divisor.
      trial_d = dqr_d[DQR_W-1:DATA_W-1] - {2'b00, divisor_d};
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
      end
   end

   always_ff @(posedge clk_i) begin
      dqr_q     <= dqr_d;
      divisor_q <= divisor_d;
      trial_q   <= trial_d;
   end

   // Result sits in the register during DONE.
   assign done_o      = (state_q == DONE);
   assign busy_o      = (state_q != IDLE);
   assign quotient_o  = dqr_q[DATA_W-1:0];
   assign remainder_o = dqr_q[2*DATA_W-1:DATA_W];

endmodule

`default_nettype wire

// File: src/div_operand_prep.sv
`timescale 1ns/1ns
`default_nettype none

module div_operand_prep
   import div_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,

   input  logic      req_valid_i,
   input  div_req_t  req_i,
   input  logic      busy_i,

   output logic      start_o,
   output word_t     dividend_o,
   output word_t     divisor_o,
   output div_meta_t meta_o
);

   logic      accept;
   logic      dividend_neg;
   logic      divisor_neg;
   logic      divisor_zero;
   word_t     dividend_abs;
   word_t     divisor_abs;
   div_meta_t meta_d;

   logic      start_q;
   word_t     dividend_q;
   word_t     divisor_q;
   div_meta_t meta_q;

   // A request is only taken while nothing is in flight.
   assign accept = req_valid_i && !busy_i;

   always_comb begin
      dividend_neg = req_i.is_signed && req_i.dividend[DATA_W-1];
      divisor_neg  = req_i.is_signed && req_i.divisor[DATA_W-1];
      divisor_zero = (req_i.divisor == '0);

      // Most negative value maps to 2**(DATA_W-1), which is the correct magnitude.
      dividend_abs = dividend_neg ? -req_i.dividend : req_i.dividend;
      divisor_abs  = divisor_neg  ? -req_i.divisor  : req_i.divisor;

      // Keep the quotient positive on divide by zero so all ones reads as -1.
      meta_d.neg_q    = (dividend_neg ^ divisor_neg) && !divisor_zero;
      meta_d.neg_r    = dividend_neg;
      meta_d.div_zero = divisor_zero;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         start_q <= 1'b0;
      end else begin
         start_q <= accept;
      end
   end

   // Operand payload, loaded with every accepted request.
   always_ff @(posedge clk_i) begin
      if (accept) begin
         dividend_q <= dividend_abs;
         divisor_q  <= divisor_abs;
         meta_q     <= meta_d;
      end
   end

   assign start_o    = start_q;
   assign dividend_o = dividend_q;
   assign divisor_o  = divisor_q;
   assign meta_o     = meta_q;

endmodule

`default_nettype wire

// File: src/div_pkg.sv
`default_nettype none

package div_pkg;

   // Operand and result width of the divide unit.
   localparam int DATA_W = 32;

   // Iteration counter, wide enough to count past DATA_W+1.
   localparam int CNT_W = $clog2(DATA_W + 2);

   // Combined remainder/quotient register, with one guard bit on top.
   localparam int DQR_W = 2 * DATA_W + 1;

   // Trial difference, one extra bit so the top bit flags a borrow.
   localparam int TRIAL_W = DATA_W + 2;

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [CNT_W-1:0]  cnt_t;

   typedef struct packed {
      word_t dividend;
      word_t divisor;
      logic  is_signed;
   } div_req_t;

   // Flags carried from the operand stage to the result stage.
   typedef struct packed {
      logic neg_q;
      logic neg_r;
      logic div_zero;
   } div_meta_t;

   typedef struct packed {
      word_t quotient;
      word_t remainder;
      logic  div_zero;
   } div_rsp_t;

   typedef enum logic [1:0] {IDLE, RUN, DONE} core_state_t;

endpackage

`default_nettype wire
